/* sources.f */
la32_pkg.sv
axi_lite_pkg.sv
la_alu.sv
la_regfile.sv
la_core.sv
axi_lite_arbiter.sv
axi_lite_ram.sv
la_soc_top.sv
tb_la_soc.sv

/* tb_la_soc.sv */
`timescale 1ns/100ps

module tb_la_soc
    import la32_pkg::*;
    import axi_lite_pkg::*;
();

    localparam int CLK_PERIOD      = 20;
    localparam int PROG_LEN        = 40;
    localparam int WATCHDOG_CYCLES = 40 * PROG_LEN + 200;
    localparam logic [31:0] DATA_BASE = 32'h0000_0100;

    logic        clk;
    logic        reset;
    logic        run;
    axil_req_t   host_req;
    axil_rsp_t   host_rsp;
    wb_trace_t   trace;

    logic [31:0] prog [PROG_LEN];
    logic [31:0] regs [32];
    wb_trace_t   exp_q [$];
    int          trace_idx;
    logic        started;

    la_soc_top #(
        .mem_words (1024)
    ) UUT (
        .clk      (clk),
        .reset    (reset),
        .run      (run),
        .host_req (host_req),
        .host_rsp (host_rsp),
        .trace    (trace)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic check_trace(input wb_trace_t got, input wb_trace_t exp);
        if (got !== exp) begin
            stop_with_failure($sformatf(
                "mismatch trace: expected pc %h wnum %h wdata %h, got pc %h wnum %h wdata %h",
                exp.pc, exp.wnum, exp.wdata, got.pc, got.wnum, got.wdata));
        end
    endtask

    task automatic check_word(input logic [31:0] addr, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("mismatch host_rsp.rdata at %h: expected %h, got %h",
                                        addr, exp, got));
        end
    endtask

    function automatic logic [31:0] sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    function automatic logic [31:0] shift_right_arith(input logic [31:0] v, input logic [4:0] sa);
        return v[31] ? ~(~v >> sa) : (v >> sa);
    endfunction

    function automatic logic [31:0] enc_3r(input logic [10:0] op11, input logic [4:0] rd,
                                           input logic [4:0] rj, input logic [4:0] rk);
        return {6'h00, op11, rk, rj, rd};  // shifts carry ui5 in the rk field.
    endfunction

    function automatic logic [31:0] enc_ri12(input logic [9:0] op10, input logic [4:0] rd,
                                             input logic [4:0] rj, input logic [11:0] imm);
        return {op10, imm, rj, rd};
    endfunction

    function automatic logic [31:0] enc_lu12i(input logic [4:0] rd, input logic [19:0] si20);
        return {7'b0001010, si20, rd};
    endfunction

    function automatic logic [31:0] enc_ri16(input logic [5:0] op6, input logic [4:0] rd,
                                             input logic [4:0] rj, input logic [15:0] offs);
        return {op6, offs, rj, rd};
    endfunction

    function automatic logic [31:0] enc_i26(input logic [5:0] op6, input logic [25:0] offs);
        return {op6, offs[15:0], offs[25:16]};
    endfunction

    // words that retire without a register write go in here.
    task automatic put(input int idx, input logic [31:0] word);
        prog[idx] = word;
    endtask

    task automatic put_wb(input int idx, input logic [31:0] word, input logic [4:0] rd,
                          input logic [31:0] value);
        wb_trace_t t;
        t.valid = 1'b1;
        t.pc    = 32'(idx * 4);
        t.wnum  = rd;
        t.wdata = value;
        exp_q.push_back(t);
        prog[idx] = word;
        if (rd != 5'd0) begin
            regs[rd] = value;
        end
    endtask

    // calls are made in execution order, so the trace queue follows the taken path.
    task automatic build_program();
        logic [19:0] hi_a;
        logic [19:0] hi_b;
        logic [11:0] lo_a;
        logic [11:0] lo_b;
        logic [4:0]  sa;
        logic [31:0] a;
        logic [31:0] b;
        hi_a = 20'($urandom());
        hi_b = 20'($urandom());
        lo_a = 12'($urandom());
        lo_b = 12'($urandom());
        sa   = 5'($urandom_range(31, 1));
        foreach (regs[i]) begin
            regs[i] = 32'd0;
        end
        put_wb(0, enc_lu12i(4, hi_a), 4, {hi_a, 12'h000});
        put_wb(1, enc_ri12(10'h00a, 4, 4, lo_a), 4, regs[4] + sext12(lo_a));
        put_wb(2, enc_lu12i(5, hi_b), 5, {hi_b, 12'h000});
        put_wb(3, enc_ri12(10'h00a, 5, 5, lo_b), 5, regs[5] + sext12(lo_b));
        a = regs[4];
        b = regs[5];
        put_wb(4, enc_3r(11'h020, 6, 4, 5), 6, a + b);
        put_wb(5, enc_3r(11'h022, 7, 4, 5), 7, a - b);
        put_wb(6, enc_3r(11'h024, 8, 4, 5), 8, (a[31] != b[31]) ? {31'd0, a[31]} : {31'd0, a < b});
        put_wb(7, enc_3r(11'h025, 9, 4, 5), 9, {31'd0, a < b});
        put_wb(8, enc_3r(11'h029, 10, 4, 5), 10, a & b);
        put_wb(9, enc_3r(11'h02a, 11, 4, 5), 11, a | b);
        put_wb(10, enc_3r(11'h028, 12, 4, 5), 12, ~(a | b));
        put_wb(11, enc_3r(11'h02b, 13, 4, 5), 13, a ^ b);
        put_wb(12, enc_3r(11'h081, 14, 4, sa), 14, a << sa);
        put_wb(13, enc_3r(11'h089, 15, 4, sa), 15, a >> sa);
        put_wb(14, enc_3r(11'h091, 16, 4, sa), 16, shift_right_arith(a, sa));
        put_wb(15, enc_ri12(10'h00a, 0, 4, 12'h123), 0, a + 32'h123);  // r0 stays zero.
        put_wb(16, enc_3r(11'h020, 17, 0, 5), 17, b);
        put_wb(17, enc_3r(11'h020, 18, 4, 0), 18, a);
        put_wb(18, enc_ri12(10'h00a, 20, 0, DATA_BASE[11:0]), 20, DATA_BASE);
        put(19, enc_ri12(10'h0a6, 6, 20, 12'h000));
        put(20, enc_ri12(10'h0a6, 7, 20, 12'h008));
        put_wb(21, enc_ri12(10'h0a2, 21, 20, 12'h000), 21, regs[6]);
        put_wb(22, enc_ri12(10'h0a2, 22, 20, 12'h008), 22, regs[7]);
        put(23, enc_ri16(6'h16, 4, 4, 16'd2));  // taken beq.
        put(24, enc_ri12(10'h00a, 23, 0, 12'd1));
        put(25, enc_ri16(6'h17, 4, 4, 16'd2));  // untaken bne.
        put_wb(26, enc_ri12(10'h00a, 23, 0, 12'd7), 23, 32'd7);
        put(27, enc_ri16(6'h16, 23, 0, 16'd2));
        put(28, enc_ri16(6'h17, 0, 23, 16'd2));
        put(29, enc_ri12(10'h00a, 24, 0, 12'd9));
        put(30, enc_i26(6'h14, 26'd2));
        put(31, enc_ri12(10'h00a, 24, 0, 12'd10));
        put_wb(32, enc_i26(6'h15, 26'd3), 1, 32'(32 * 4 + 4));
        put_wb(35, enc_ri12(10'h00a, 26, 0, 12'd12), 26, 32'd12);
        put_wb(36, enc_ri16(6'h13, 27, 1, 16'd0), 27, 32'(36 * 4 + 4));
        put(37, enc_ri12(10'h00a, 28, 0, 12'd13));
        put_wb(33, enc_ri12(10'h00a, 25, 0, 12'd11), 25, 32'd11);
        put(34, enc_i26(6'h14, 26'd4));
        put_wb(38, enc_ri12(10'h0a2, 29, 20, 12'h008), 29, regs[7]);
        put(39, enc_i26(6'h14, 26'd0));  // the core parks here.
    endtask

    task automatic host_write(input logic [31:0] addr, input logic [31:0] data);
        int unsigned delay;
        delay = $urandom_range(3, 0);
        host_req.awvalid = 1'b1;
        host_req.awaddr  = addr;
        host_req.wvalid  = 1'b1;
        host_req.wdata   = data;
        host_req.wstrb   = 4'hf;
        do begin
            @(negedge clk);
        end while (!host_rsp.awready);
        if (host_rsp.wready !== 1'b1) begin
            stop_with_failure("the write address was accepted without the write data");
        end
        @(posedge clk);
        #1;
        host_req.awvalid = 1'b0;
        host_req.wvalid  = 1'b0;
        repeat (delay) begin
            @(posedge clk);
            #1;
        end
        host_req.bready = 1'b1;
        do begin
            @(negedge clk);
        end while (!host_rsp.bvalid);
        @(posedge clk);
        #1;
        host_req.bready = 1'b0;
    endtask

    task automatic host_read(input logic [31:0] addr, output logic [31:0] data);
        int unsigned delay;
        delay = $urandom_range(3, 0);
        host_req.arvalid = 1'b1;
        host_req.araddr  = addr;
        do begin
            @(negedge clk);
        end while (!host_rsp.arready);
        @(posedge clk);
        #1;
        host_req.arvalid = 1'b0;
        repeat (delay) begin
            @(posedge clk);
            #1;
        end
        host_req.rready = 1'b1;
        do begin
            @(negedge clk);
        end while (!host_rsp.rvalid);
        data = host_rsp.rdata;
        @(posedge clk);
        #1;
        host_req.rready = 1'b0;
    endtask

    always @(negedge clk) begin
        if (!reset && trace.valid === 1'b1) begin
            if (!started) begin
                stop_with_failure("trace.valid was raised while run was still low");
            end else if (trace_idx >= exp_q.size()) begin
                stop_with_failure("trace.valid was raised after the last expected record");
            end else begin
                check_trace(trace, exp_q[trace_idx]);
                trace_idx++;
            end
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        stop_with_failure("timeout, the core stopped retiring instructions");
    end

    initial begin
        logic [31:0] word;
        clk       = 1'b0;
        reset     = 1'b1;
        run       = 1'b0;
        host_req  = '0;
        trace_idx = 0;
        started   = 1'b0;
        void'($urandom(32'hf914_c55e));
        build_program();
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;
        for (int i = 0; i < PROG_LEN; i++) begin
            host_write(32'(i * 4), prog[i]);
        end
        started = 1'b1;
        run     = 1'b1;
        wait (trace_idx == exp_q.size());
        @(posedge clk);
        #1;
        run = 1'b0;  // the self-loop drops to idle once run is low.
        repeat (10) @(posedge clk);
        #1;
        host_read(DATA_BASE, word);
        check_word(DATA_BASE, word, regs[6]);
        host_read(DATA_BASE + 32'd8, word);
        check_word(DATA_BASE + 32'd8, word, regs[7]);
        for (int i = 0; i < PROG_LEN; i++) begin
            host_read(32'(i * 4), word);
            check_word(32'(i * 4), word, prog[i]);
        end
        $display("Verification passed");
        $finish;
    end

endmodule

/* la_soc_top.sv */
`timescale 1ns/100ps

module la_soc_top
    import la32_pkg::*;
    import axi_lite_pkg::*;
#(
    parameter int mem_words = 1024
) (
    input  logic      clk,
    input  logic      reset,
    input  logic      run,
    input  axil_req_t host_req,
    output axil_rsp_t host_rsp,
    output wb_trace_t trace
);

    axil_req_t m_req [NUM_MASTERS];
    axil_rsp_t m_rsp [NUM_MASTERS];
    axil_req_t s_req;
    axil_rsp_t s_rsp;

    assign m_req[2] = host_req;  // host is master 2.
    assign host_rsp = m_rsp[2];

    la_core u_core (
        .clk        (clk),
        .reset      (reset),
        .run        (run),
        .ifetch_req (m_req[0]),
        .ifetch_rsp (m_rsp[0]),
        .data_req   (m_req[1]),
        .data_rsp   (m_rsp[1]),
        .trace      (trace)
    );

    axi_lite_arbiter u_arbiter (
        .clk   (clk),
        .reset (reset),
        .m_req (m_req),
        .m_rsp (m_rsp),
        .s_req (s_req),
        .s_rsp (s_rsp)
    );

    axi_lite_ram #(
        .mem_words (mem_words)
    ) u_ram (
        .clk   (clk),
        .reset (reset),
        .req   (s_req),
        .rsp   (s_rsp)
    );

endmodule

/* axi_lite_ram.sv */
`timescale 1ns/100ps

module axi_lite_ram
    import axi_lite_pkg::*;
#(
    parameter int mem_words = 1024
) (
    input  logic      clk,
    input  logic      reset,
    input  axil_req_t req,
    output axil_rsp_t rsp
);

    localparam int AW = $clog2(mem_words);

    logic [31:0]   mem [mem_words];
    logic [31:0]   rdata_q;
    logic          r_pend;
    logic          b_pend;
    logic          idle;
    logic          wr_fire;
    logic          rd_fire;
    logic [AW-1:0] widx;
    logic [AW-1:0] ridx;

    assign idle    = !r_pend && !b_pend;
    assign widx    = AW'(req.awaddr[31:2] % mem_words);
    assign ridx    = AW'(req.araddr[31:2] % mem_words);
    assign wr_fire = req.awvalid && idle;
    assign rd_fire = req.arvalid && rsp.arready;

    assign rsp.awready = idle;
    assign rsp.wready  = idle;
    assign rsp.arready = idle && !req.awvalid;  // a write wins a same-cycle tie.
    assign rsp.bvalid  = b_pend;
    assign rsp.rvalid  = r_pend;
    assign rsp.rdata   = rdata_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            r_pend <= 1'b0;
            b_pend <= 1'b0;
        end else begin
            r_pend <= rd_fire || (r_pend && !req.rready);
            b_pend <= wr_fire || (b_pend && !req.bready);
        end
    end

    always_ff @(posedge clk) begin
        if (rd_fire) begin
            rdata_q <= mem[ridx];
        end
        for (int b = 0; b < 4; b++) begin
            if (wr_fire && req.wstrb[b]) begin
                mem[widx][8*b +: 8] <= req.wdata[8*b +: 8];
            end
        end
    end

    a_aw_with_w: assert property (@(posedge clk) disable iff (reset)
        req.awvalid |-> req.wvalid);

endmodule

/* axi_lite_arbiter.sv */
`timescale 1ns/100ps

module axi_lite_arbiter
    import axi_lite_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  axil_req_t m_req [NUM_MASTERS],
    output axil_rsp_t m_rsp [NUM_MASTERS],
    output axil_req_t s_req,
    input  axil_rsp_t s_rsp
);

    localparam int IDX_W = $clog2(NUM_MASTERS);

    logic [IDX_W-1:0] grant;
    logic [IDX_W-1:0] last;
    logic [IDX_W-1:0] pick;
    logic             busy;
    logic             any_req;
    logic             done;

    // the scan runs from the farthest master down so the one after last wins.
    always_comb begin
        int idx;
        pick    = last;
        any_req = 1'b0;
        for (int i = NUM_MASTERS; i >= 1; i--) begin
            idx = (int'(last) + i) % NUM_MASTERS;
            if (m_req[idx].arvalid || m_req[idx].awvalid) begin
                pick    = IDX_W'(idx);
                any_req = 1'b1;
            end
        end
    end

    assign done = busy && ((s_rsp.rvalid && s_req.rready) || (s_rsp.bvalid && s_req.bready));

    always_ff @(posedge clk) begin
        if (reset) begin
            busy  <= 1'b0;
            grant <= '0;
            last  <= IDX_W'(NUM_MASTERS - 1);
        end else if (!busy && any_req) begin
            busy  <= 1'b1;
            grant <= pick;
        end else if (done) begin
            busy <= 1'b0;
            last <= grant;
        end
    end

    always_comb begin
        s_req = busy ? m_req[grant] : '0;
        for (int i = 0; i < NUM_MASTERS; i++) begin
            m_rsp[i] = (busy && grant == i) ? s_rsp : '0;
        end
    end

    a_grant_held: assert property (@(posedge clk) disable iff (reset)
        busy |=> $stable(grant));

    a_idle_quiet: assert property (@(posedge clk) disable iff (reset)
        (!busy && !any_req) |-> !(s_req.arvalid || s_req.awvalid || s_req.wvalid));

endmodule

/* la_core.sv */
`timescale 1ns/100ps

module la_core
    import la32_pkg::*;
    import axi_lite_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      run,
    output axil_req_t ifetch_req,
    input  axil_rsp_t ifetch_rsp,
    output axil_req_t data_req,
    input  axil_rsp_t data_rsp,
    output wb_trace_t trace
);

    core_state_e state;
    core_state_e next_fetch;
    logic [31:0] pc;
    logic [31:0] inst;
    logic [31:0] res;
    logic        addr_sent;
    inst_op_e    op;
    alu_op_e     alu_op;
    logic [31:0] imm;
    logic [31:0] offs16;
    logic [31:0] offs26;
    logic [31:0] rj_value;
    logic [31:0] rkd_value;
    logic [31:0] alu_src1;
    logic [31:0] alu_src2;
    logic [31:0] alu_result;
    logic [31:0] br_target;
    logic [31:0] next_pc;
    logic [4:0]  dest;
    logic        br_taken;
    logic        is_load;
    logic        fetch_a;
    logic        fetch_r;
    logic        data_a;
    logic        data_resp;

    always_comb begin
        op = INST_INVALID;
        case (inst[31:26])
            6'h00: begin
                case (inst[25:15])
                    11'h020: op = INST_ADD_W;
                    11'h022: op = INST_SUB_W;
                    11'h024: op = INST_SLT;
                    11'h025: op = INST_SLTU;
                    11'h028: op = INST_NOR;
                    11'h029: op = INST_AND;
                    11'h02a: op = INST_OR;
                    11'h02b: op = INST_XOR;
                    11'h081: op = INST_SLLI_W;
                    11'h089: op = INST_SRLI_W;
                    11'h091: op = INST_SRAI_W;
                    default: op = (inst[25:22] == 4'ha) ? INST_ADDI_W : INST_INVALID;
                endcase
            end
            6'h05:   op = inst[25] ? INST_INVALID : INST_LU12I_W;
            6'h0a:   op = (inst[25:22] == 4'h2) ? INST_LD_W :
                          (inst[25:22] == 4'h6) ? INST_ST_W : INST_INVALID;
            6'h13:   op = INST_JIRL;
            6'h14:   op = INST_B;
            6'h15:   op = INST_BL;
            6'h16:   op = INST_BEQ;
            6'h17:   op = INST_BNE;
            default: op = INST_INVALID;
        endcase
    end

    always_comb begin
        case (op)
            INST_SUB_W:   alu_op = ALU_SUB;
            INST_SLT:     alu_op = ALU_SLT;
            INST_SLTU:    alu_op = ALU_SLTU;
            INST_AND:     alu_op = ALU_AND;
            INST_NOR:     alu_op = ALU_NOR;
            INST_OR:      alu_op = ALU_OR;
            INST_XOR:     alu_op = ALU_XOR;
            INST_SLLI_W:  alu_op = ALU_SLL;
            INST_SRLI_W:  alu_op = ALU_SRL;
            INST_SRAI_W:  alu_op = ALU_SRA;
            INST_LU12I_W: alu_op = ALU_LUI;
            default:      alu_op = ALU_ADD;  // also addresses and the link value.
        endcase
    end

    assign imm = (op inside {INST_SLLI_W, INST_SRLI_W, INST_SRAI_W}) ? {27'd0, inst[14:10]} :
                 (op == INST_LU12I_W)           ? {inst[24:5], 12'd0} :
                 (op inside {INST_JIRL, INST_BL}) ? 32'd4 :
                                                    {{20{inst[21]}}, inst[21:10]};
    assign offs16 = {{14{inst[25]}}, inst[25:10], 2'b00};
    assign offs26 = {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b00};

    la_regfile u_regfile (
        .clk    (clk),
        .raddr1 (inst[9:5]),
        .raddr2 (op inside {INST_BEQ, INST_BNE, INST_ST_W} ? inst[4:0] : inst[14:10]),
        .rdata1 (rj_value),
        .rdata2 (rkd_value),
        .we     (state == ST_WRITEBACK),
        .waddr  (dest),
        .wdata  (res)
    );

    assign alu_src1 = (op inside {INST_JIRL, INST_BL}) ? pc : rj_value;
    assign alu_src2 = (op inside {INST_ADD_W, INST_SUB_W, INST_SLT, INST_SLTU, INST_NOR,
                                  INST_AND, INST_OR, INST_XOR}) ? rkd_value : imm;

    la_alu u_alu (
        .op     (alu_op),
        .src1   (alu_src1),
        .src2   (alu_src2),
        .result (alu_result)
    );

    assign dest      = (op == INST_BL) ? 5'd1 : inst[4:0];
    assign br_taken  = (op == INST_BEQ && rj_value == rkd_value) ||
                       (op == INST_BNE && rj_value != rkd_value) ||
                       (op inside {INST_B, INST_BL, INST_JIRL});
    assign br_target = (op == INST_JIRL) ? rj_value + offs16 :
                       (op inside {INST_B, INST_BL}) ? pc + offs26 : pc + offs16;
    assign next_pc    = br_taken ? br_target : pc + 32'd4;
    assign next_fetch = run ? ST_FETCH : ST_IDLE;  // run low parks the core between instructions.
    assign is_load    = (op == INST_LD_W);

    always_comb begin
        ifetch_req = '0;
        ifetch_req.arvalid = (state == ST_FETCH) && !addr_sent;
        ifetch_req.araddr  = pc;
        ifetch_req.rready  = (state == ST_FETCH) && addr_sent;
        data_req = '0;
        data_req.arvalid = (state == ST_MEMORY) && is_load && !addr_sent;
        data_req.araddr  = res;
        data_req.rready  = (state == ST_MEMORY) && is_load && addr_sent;
        data_req.awvalid = (state == ST_MEMORY) && !is_load && !addr_sent;
        data_req.awaddr  = res;
        data_req.wvalid  = data_req.awvalid;
        data_req.wdata   = rkd_value;
        data_req.wstrb   = 4'hf;
        data_req.bready  = (state == ST_MEMORY) && !is_load && addr_sent;
    end

    assign fetch_a   = ifetch_req.arvalid && ifetch_rsp.arready;
    assign fetch_r   = ifetch_req.rready && ifetch_rsp.rvalid;
    assign data_a    = (data_req.arvalid && data_rsp.arready) ||
                       (data_req.awvalid && data_rsp.awready);
    assign data_resp = (data_req.rready && data_rsp.rvalid) ||
                       (data_req.bready && data_rsp.bvalid);

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= ST_IDLE;
            pc        <= RESET_PC;
            addr_sent <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (run) begin
                        state <= ST_FETCH;
                    end
                end
                ST_FETCH: begin
                    if (fetch_a) begin
                        addr_sent <= 1'b1;
                    end
                    if (fetch_r) begin
                        addr_sent <= 1'b0;
                        state     <= ST_DECODE;
                    end
                end
                ST_DECODE: begin
                    if (op inside {INST_B, INST_BEQ, INST_BNE, INST_INVALID}) begin
                        pc    <= next_pc;
                        state <= next_fetch;
                    end else begin
                        state <= ST_EXECUTE;
                    end
                end
                ST_EXECUTE: state <= (is_load || op == INST_ST_W) ? ST_MEMORY : ST_WRITEBACK;
                ST_MEMORY: begin
                    if (data_a) begin
                        addr_sent <= 1'b1;
                    end
                    if (data_resp) begin
                        addr_sent <= 1'b0;
                        pc        <= is_load ? pc : next_pc;
                        state     <= is_load ? ST_WRITEBACK : next_fetch;
                    end
                end
                ST_WRITEBACK: begin
                    pc    <= next_pc;  // jirl still sees the old rj here.
                    state <= next_fetch;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_r) begin
            inst <= ifetch_rsp.rdata;
        end
        if (state == ST_EXECUTE) begin
            res <= alu_result;
        end else if (data_resp && is_load) begin
            res <= data_rsp.rdata;
        end
    end

    assign trace = '{valid: state == ST_WRITEBACK, pc: pc, wnum: dest, wdata: res};

    a_one_bus_user: assert property (@(posedge clk) disable iff (reset)
        !(ifetch_req.arvalid && (data_req.arvalid || data_req.awvalid)));

    a_trace_pulse: assert property (@(posedge clk) disable iff (reset)
        trace.valid |-> ($past(state) inside {ST_EXECUTE, ST_MEMORY}) ##1 !trace.valid);

endmodule

/* la_regfile.sv */
`timescale 1ns/100ps

module la_regfile (
    input  logic        clk,
    input  logic [4:0]  raddr1,
    input  logic [4:0]  raddr2,
    output logic [31:0] rdata1,
    output logic [31:0] rdata2,
    input  logic        we,
    input  logic [4:0]  waddr,
    input  logic [31:0] wdata
);

    logic [31:0] rf [32];

    always_ff @(posedge clk) begin
        if (we && waddr != 5'd0) begin
            rf[waddr] <= wdata;
        end
    end

    // r0 is hardwired to zero on the read side.
    assign rdata1 = (raddr1 == 5'd0) ? 32'd0 : rf[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? 32'd0 : rf[raddr2];

endmodule

/* la_alu.sv */
`timescale 1ns/100ps

module la_alu
    import la32_pkg::*;
(
    input  alu_op_e     op,
    input  logic [31:0] src1,
    input  logic [31:0] src2,
    output logic [31:0] result
);

    logic [4:0] shamt;

    assign shamt = src2[4:0];

    always_comb begin
        case (op)
            ALU_ADD:  result = src1 + src2;
            ALU_SUB:  result = src1 - src2;
            ALU_SLT:  result = {31'd0, $signed(src1) < $signed(src2)};
            ALU_SLTU: result = {31'd0, src1 < src2};
            ALU_AND:  result = src1 & src2;
            ALU_NOR:  result = ~(src1 | src2);
            ALU_OR:   result = src1 | src2;
            ALU_XOR:  result = src1 ^ src2;
            ALU_SLL:  result = src1 << shamt;
            ALU_SRL:  result = src1 >> shamt;
            ALU_SRA:  result = $unsigned($signed(src1) >>> shamt);
            ALU_LUI:  result = src2;  // the immediate arrives already shifted.
            default:  result = 32'd0;
        endcase
    end

endmodule

/* axi_lite_pkg.sv */
package axi_lite_pkg;

    localparam int NUM_MASTERS = 3;  // fetch, data and host.

    typedef struct packed {
        logic        awvalid;
        logic [31:0] awaddr;
        logic        wvalid;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
        logic        bready;
        logic        arvalid;
        logic [31:0] araddr;
        logic        rready;
    } axil_req_t;

    // responses are always OKAY, so no resp fields are carried.
    typedef struct packed {
        logic        awready;
        logic        wready;
        logic        bvalid;
        logic        arready;
        logic        rvalid;
        logic [31:0] rdata;
    } axil_rsp_t;

endpackage

/* la32_pkg.sv */
package la32_pkg;

    localparam logic [31:0] RESET_PC = 32'h0000_0000;

    typedef enum logic [4:0] {
        INST_ADD_W,
        INST_SUB_W,
        INST_SLT,
        INST_SLTU,
        INST_NOR,
        INST_AND,
        INST_OR,
        INST_XOR,
        INST_SLLI_W,
        INST_SRLI_W,
        INST_SRAI_W,
        INST_ADDI_W,
        INST_LD_W,
        INST_ST_W,
        INST_JIRL,
        INST_B,
        INST_BL,
        INST_BEQ,
        INST_BNE,
        INST_LU12I_W,
        INST_INVALID  // anything outside the subset retires as a no-op.
    } inst_op_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_AND, ALU_NOR,
        ALU_OR, ALU_XOR, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
    } alu_op_e;

    typedef enum logic [2:0] {
        ST_IDLE, ST_FETCH, ST_DECODE, ST_EXECUTE, ST_MEMORY, ST_WRITEBACK
    } core_state_e;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [4:0]  wnum;
        logic [31:0] wdata;
    } wb_trace_t;

endpackage
